/* include/lf_defs.svh */
// LF front end parameters
`ifndef LF_DEFS_SVH
`define LF_DEFS_SVH

// --------------------
// data path widths
// --------------------

// one ADC sample
`define LF_SAMPLE_W 8

// carrier divisor, which is the half period minus one
`define LF_DIV_W 8

// configuration word loaded by the host, MSB first
`define LF_CFG_W 16

// --------------------
// carrier divisor limits
// --------------------

// 96-cycle half period, so 125 kHz from a 24 MHz pck0
`define LF_DIV_RESET 95

// leaves room for one full serial word in each carrier cycle
`define LF_DIV_MIN 40

// --------------------
// edge comparator
// --------------------

// level rises at or above HI and falls at or below LO
`define LF_EDGE_HI 160
`define LF_EDGE_LO 96

// --------------------
// SSP serializer timing
// --------------------

// the bit-time counter covers 8 bits of 4 cycles each
`define LF_SSP_CNT_W 5

// low counter bits give the phase within one bit
`define LF_SSP_PHASE_W 2

`endif

/* rtl/lf_pkg.sv */
// LF front end types
`default_nettype none

`include "lf_defs.svh"

package lf_pkg;

    // --------------------
    // vector types
    // --------------------

    // raw ADC sample
    typedef logic [`LF_SAMPLE_W-1:0] sample_t;

    // carrier half period minus one, in pck0 cycles
    typedef logic [`LF_DIV_W-1:0] divisor_t;

    // operating mode, the codes match bits 15:14 of the host word
    typedef enum logic [1:0] {
        mode_off  = 2'b00,
        mode_read = 2'b01,
        mode_edge = 2'b10
    } lf_mode_e;

    // --------------------
    // grouped signals
    // --------------------

    // applied configuration, 10 bits
    typedef struct packed {
        lf_mode_e mode;
        divisor_t divisor;
    } lf_config_t;

    // a captured sample with its one-cycle strobe
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_strobe_t;

    // synchronous serial port toward the host
    typedef struct packed {
        logic frame;
        logic din;
        logic clk;
    } ssp_t;

    // coil driver pins
    typedef struct packed {
        logic pwr_lo;
        logic pwr_hi;
        logic pwr_oe1;
        logic pwr_oe2;
        logic pwr_oe3;
        logic pwr_oe4;
    } coil_t;

endpackage

`default_nettype wire

/* rtl/lf_config_rx.sv */
// Host configuration receiver
`default_nettype none

`include "lf_defs.svh"

module lf_config_rx (
    input  logic               pck0,
    input  logic               reset,
    input  logic               spck,
    input  logic               sdata,
    input  logic               ncs,
    output lf_pkg::lf_config_t cfg
);

    // two synchronizer stages, each holding {ncs, spck, sdata}
    logic [2:0] sync_1;
    logic [2:0] sync_2;

    // previous synchronized ncs and spck, for edge detection
    logic ncs_q;
    logic spck_q;

    // word being shifted in from the host
    logic [`LF_CFG_W-1:0] shift_q;

    // decoded and clamped version of shift_q
    lf_pkg::lf_config_t next_cfg;

    logic spck_rise;
    logic ncs_rise;

    // --------------------
    // synchronizers
    // --------------------

    // ncs idles high, so it resets high to avoid a false apply edge
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            sync_1 <= 3'b100;
            sync_2 <= 3'b100;
            ncs_q  <= 1'b1;
            spck_q <= 1'b0;
        end
        else
        begin
            sync_1 <= {ncs, spck, sdata};
            sync_2 <= sync_1;
            ncs_q  <= sync_2[2];
            spck_q <= sync_2[1];
        end
    end

    // sdata is delayed by the same two stages as spck, so it is still
    // settled when the synchronized clock edge shows up
    assign spck_rise = sync_2[1] && !spck_q && !sync_2[2];
    assign ncs_rise  = sync_2[2] && !ncs_q;

    // --------------------
    // shift register
    // --------------------

    // MSB arrives first
    always_ff @(posedge pck0)
    begin
        if (spck_rise)
        begin
            shift_q <= {shift_q[`LF_CFG_W-2:0], sync_2[0]};
        end
    end

    // --------------------
    // decode and apply
    // --------------------

    always_comb
    begin
        // mode sits in the two top bits of the word
        case (shift_q[`LF_CFG_W-1 -: 2])
            2'b01:   next_cfg.mode = lf_pkg::mode_read;
            2'b10:   next_cfg.mode = lf_pkg::mode_edge;
            default: next_cfg.mode = lf_pkg::mode_off;
        endcase
        // a divisor too short for one serial word per cycle is raised
        if (shift_q[`LF_DIV_W-1:0] < lf_pkg::divisor_t'(`LF_DIV_MIN))
        begin
            next_cfg.divisor = lf_pkg::divisor_t'(`LF_DIV_MIN);
        end
        else
        begin
            next_cfg.divisor = shift_q[`LF_DIV_W-1:0];
        end
    end

    // the word takes effect on the end of the ncs transfer, three
    // cycles after ncs rises at the pin
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            cfg.mode    <= lf_pkg::mode_off;
            cfg.divisor <= lf_pkg::divisor_t'(`LF_DIV_RESET);
        end
        else if (ncs_rise)
        begin
            cfg <= next_cfg;
        end
    end

    // the reader counts on the clamp, whatever the host sent
    a_div_clamped : assert property (@(posedge pck0) disable iff (reset)
        cfg.divisor >= lf_pkg::divisor_t'(`LF_DIV_MIN))
        else $error("applied divisor below the minimum");

endmodule

`default_nettype wire

/* rtl/lf_reader.sv */
// LF carrier and sample serializer
`default_nettype none

`include "lf_defs.svh"

module lf_reader (
    input  logic                   pck0,
    input  logic                   reset,
    input  lf_pkg::divisor_t       divisor,
    input  lf_pkg::sample_t        adc_d,
    output logic                   carrier,
    output logic                   adc_clk,
    output lf_pkg::ssp_t           ssp,
    output lf_pkg::sample_strobe_t sample
);

    // carrier half period down counter and the coil level
    lf_pkg::divisor_t half_cnt;
    logic             carrier_q;

    // high in the cycle before the carrier goes from 0 to 1
    logic capture;

    // captured sample and its strobe
    lf_pkg::sample_t cap_q;
    logic            valid_q;

    // serializer state
    logic                        busy;
    logic [`LF_SSP_CNT_W-1:0]    bit_cnt;
    logic [`LF_SSP_PHASE_W-1:0]  phase;
    lf_pkg::sample_t             shift_q;

    assign capture = (half_cnt == '0) && !carrier_q;
    assign phase   = bit_cnt[`LF_SSP_PHASE_W-1:0];

    // --------------------
    // carrier divider
    // --------------------

    // the counter reloads at zero and the carrier toggles there, so each
    // half period lasts divisor+1 cycles
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            half_cnt  <= '0;
            carrier_q <= 1'b0;
            valid_q   <= 1'b0;
        end
        else
        begin
            // the strobe lines up with the carrier rising edge
            valid_q <= capture;
            if (half_cnt == '0)
            begin
                half_cnt  <= divisor;
                carrier_q <= ~carrier_q;
            end
            else
            begin
                half_cnt <= half_cnt - 1'b1;
            end
        end
    end

    // sample taken on the falling edge of adc_clk
    always_ff @(posedge pck0)
    begin
        if (capture)
        begin
            cap_q <= adc_d;
        end
    end

    // --------------------
    // SSP serializer
    // --------------------

    // bit_cnt runs through the whole 32-cycle word and then stops
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end
        else if (capture)
        begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end
        else if (busy)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == '1)
            begin
                busy <= 1'b0;
            end
        end
    end

    // the next bit moves up only after the clock high phase has ended
    always_ff @(posedge pck0)
    begin
        if (capture)
        begin
            shift_q <= adc_d;
        end
        else if (busy && (phase == '1))
        begin
            shift_q <= {shift_q[`LF_SAMPLE_W-2:0], 1'b0};
        end
    end

    assign carrier      = carrier_q;
    assign adc_clk      = ~carrier_q;
    assign sample.valid = valid_q;
    assign sample.data  = cap_q;

    // frame covers bit 7 only, clk is high in the last two cycles of a bit
    assign ssp.frame = busy && (bit_cnt[`LF_SSP_CNT_W-1:`LF_SSP_PHASE_W] == '0);
    assign ssp.clk   = busy && phase[`LF_SSP_PHASE_W-1];
    assign ssp.din   = shift_q[`LF_SAMPLE_W-1];

    // a word must be out before the next one overwrites the shift register
    a_ssp_idle : assert property (@(posedge pck0) disable iff (reset)
        capture |-> !busy)
        else $error("serializer still busy at the next capture");

    // the config receiver is trusted to clamp the divisor
    a_div_min : assert property (@(posedge pck0) disable iff (reset)
        divisor >= lf_pkg::divisor_t'(`LF_DIV_MIN))
        else $error("divisor below the minimum");

endmodule

`default_nettype wire

/* rtl/lf_edge_detect.sv */
// Hysteresis edge comparator
`default_nettype none

`include "lf_defs.svh"

module lf_edge_detect (
    input  logic                   pck0,
    input  logic                   reset,
    input  lf_pkg::sample_strobe_t sample,
    output logic                   level
);

    logic level_q;
    logic above_hi;
    logic below_lo;

    // --------------------
    // threshold compare
    // --------------------

    // both limits are inclusive
    assign above_hi = sample.data >= lf_pkg::sample_t'(`LF_EDGE_HI);
    assign below_lo = sample.data <= lf_pkg::sample_t'(`LF_EDGE_LO);

    // --------------------
    // level register
    // --------------------

    // samples in the band between the limits keep the old level
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            level_q <= 1'b0;
        end
        else if (sample.valid)
        begin
            if (above_hi)
            begin
                level_q <= 1'b1;
            end
            else if (below_lo)
            begin
                level_q <= 1'b0;
            end
        end
    end

    assign level = level_q;

    // each captured sample must be applied once, so the strobe lasts one cycle
    a_single_strobe : assert property (@(posedge pck0) disable iff (reset)
        sample.valid |=> !sample.valid)
        else $error("sample strobe longer than one cycle");

endmodule

`default_nettype wire

/* rtl/lf_output_select.sv */
// Per-mode output register
`default_nettype none

module lf_output_select (
    input  logic             pck0,
    input  logic             reset,
    input  lf_pkg::lf_mode_e mode,
    input  logic             carrier,
    input  logic             adc_clk_in,
    input  logic             level,
    input  lf_pkg::ssp_t     ssp_in,
    output lf_pkg::coil_t    coil,
    output logic             adc_clk,
    output lf_pkg::ssp_t     ssp
);

    // next values for every output
    lf_pkg::coil_t coil_d;
    logic          adc_clk_d;
    lf_pkg::ssp_t  ssp_d;

    // --------------------
    // mode mux
    // --------------------

    always_comb
    begin
        // pwr_hi and the four enables are never driven in this design
        coil_d    = '0;
        adc_clk_d = 1'b0;
        ssp_d     = '0;
        case (mode)
            lf_pkg::mode_read:
            begin
                coil_d.pwr_lo = carrier;
                adc_clk_d     = adc_clk_in;
                ssp_d         = ssp_in;
            end
            lf_pkg::mode_edge:
            begin
                // the comparator level replaces the byte, no framing
                coil_d.pwr_lo = carrier;
                adc_clk_d     = adc_clk_in;
                ssp_d.din     = level;
            end
            default:
            begin
                // off, coil and port stay quiet
                coil_d    = '0;
                adc_clk_d = 1'b0;
                ssp_d     = '0;
            end
        endcase
    end

    // --------------------
    // output flops
    // --------------------

    // one register stage keeps the pins free of mux glitches
    always_ff @(posedge pck0)
    begin
        if (reset)
        begin
            coil    <= '0;
            adc_clk <= 1'b0;
            ssp     <= '0;
        end
        else
        begin
            coil    <= coil_d;
            adc_clk <= adc_clk_d;
            ssp     <= ssp_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/lf_frontend.sv */
// LF reader front end top
`default_nettype none

module lf_frontend (
    input  logic            pck0,
    input  logic            reset,
    input  logic            spck,
    input  logic            sdata,
    input  logic            ncs,
    input  lf_pkg::sample_t adc_d,
    output lf_pkg::coil_t   coil,
    output logic            adc_clk,
    output lf_pkg::ssp_t    ssp
);

    // --------------------
    // internal nets
    // --------------------

    // configuration applied from the host word
    lf_pkg::lf_config_t cfg;

    // raw reader outputs, before the mode register
    logic                   carrier;
    logic                   reader_adc_clk;
    lf_pkg::ssp_t           reader_ssp;
    lf_pkg::sample_strobe_t sample;

    // comparator level for edge mode
    logic level;

    // --------------------
    // blocks
    // --------------------

    // host serial link to configuration register
    lf_config_rx config_rx_i (
        .pck0  (pck0),
        .reset (reset),
        .spck  (spck),
        .sdata (sdata),
        .ncs   (ncs),
        .cfg   (cfg)
    );

    // carrier, ADC clock and sample serializer
    lf_reader reader_i (
        .pck0    (pck0),
        .reset   (reset),
        .divisor (cfg.divisor),
        .adc_d   (adc_d),
        .carrier (carrier),
        .adc_clk (reader_adc_clk),
        .ssp     (reader_ssp),
        .sample  (sample)
    );

    // hysteresis on the captured samples
    lf_edge_detect edge_detect_i (
        .pck0   (pck0),
        .reset  (reset),
        .sample (sample),
        .level  (level)
    );

    // all pins leave through one register stage
    lf_output_select output_select_i (
        .pck0       (pck0),
        .reset      (reset),
        .mode       (cfg.mode),
        .carrier    (carrier),
        .adc_clk_in (reader_adc_clk),
        .level      (level),
        .ssp_in     (reader_ssp),
        .coil       (coil),
        .adc_clk    (adc_clk),
        .ssp        (ssp)
    );

endmodule

`default_nettype wire

/* testbench/lf_frontend_tb.sv */
// LF front end testbench
`default_nettype none

`include "lf_defs.svh"

module lf_frontend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // DUT pins
    logic            pck0;
    logic            reset;
    logic            spck;
    logic            sdata;
    logic            ncs;
    lf_pkg::sample_t adc_d;
    lf_pkg::coil_t   coil;
    logic            adc_clk;
    lf_pkg::ssp_t    ssp;

    // random source and bookkeeping
    integer seed;
    int     checks;
    int     errors;
    int     tests_run;
    int     mark_checks;
    int     mark_errors;

    // reference model state, all sampled on the falling clock edge
    logic            lo_prev;
    lf_pkg::sample_t expected_byte;
    logic            model_level;
    logic            near_thresholds;

    lf_frontend dut_i (
        .pck0    (pck0),
        .reset   (reset),
        .spck    (spck),
        .sdata   (sdata),
        .ncs     (ncs),
        .adc_d   (adc_d),
        .coil    (coil),
        .adc_clk (adc_clk),
        .ssp     (ssp)
    );

    // 100 ns pck0
    always #50 pck0 = ~pck0;

    // --------------------
    // helpers
    // --------------------

    // random ADC value, optionally clustered around the two thresholds
    function automatic lf_pkg::sample_t new_sample(input logic near);
        logic [31:0] r;
        int          offset;
        r      = $random(seed);
        offset = int'(r[10:8] % 3'd5) - 2;
        if (near && r[2:0] < 3'd3)
        begin
            return lf_pkg::sample_t'(`LF_EDGE_HI + offset);
        end
        else if (near && r[2:0] < 3'd6)
        begin
            return lf_pkg::sample_t'(`LF_EDGE_LO + offset);
        end
        return r[23:16];
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("** Error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("timeout: gave up waiting for %s at %0t ns", what, $time);
        $display("Verification failed");
        $finish;
    endtask

    task automatic start_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %s: %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
    endtask

    // all pins are quiet in off mode and after reset
    function automatic bit outputs_low();
        return (coil == '0) && !adc_clk && (ssp == '0);
    endfunction

    // host word, MSB first, 4 pck0 cycles per spck half period
    task automatic write_config(input logic [1:0] mode_code,
                                input lf_pkg::divisor_t divisor,
                                input int settle);
        logic [`LF_CFG_W-1:0] word;
        word = {mode_code, 6'b0, divisor};
        ncs  = 1'b0;
        for (int i = `LF_CFG_W - 1; i >= 0; i--)
        begin
            sdata = word[i];
            spck  = 1'b0;
            repeat (4) @(negedge pck0);
            spck = 1'b1;
            repeat (4) @(negedge pck0);
        end
        spck = 1'b0;
        repeat (4) @(negedge pck0);
        // the word is applied a few cycles after ncs rises
        ncs = 1'b1;
        repeat (settle) @(negedge pck0);
    endtask

    // waits for any pwr_lo edge and returns the cycles since the call
    task automatic wait_lo_change(input bit check_inv, output int cycles);
        logic last;
        int   count;
        bit   seen;
        last  = coil.pwr_lo;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < 300)
        begin
            @(negedge pck0);
            count++;
            if (check_inv)
            begin
                check(adc_clk == !coil.pwr_lo, "adc_clk is not the inverse of pwr_lo");
                // the high-side driver and the four enables stay low in read mode
                check({coil.pwr_hi, coil.pwr_oe1, coil.pwr_oe2, coil.pwr_oe3,
                       coil.pwr_oe4} == 5'b0, "pwr_hi or an output enable is driven");
            end
            seen = (coil.pwr_lo != last);
            last = coil.pwr_lo;
        end
        cycles = count;
        if (!seen)
        begin
            fail_on_timeout("a pwr_lo edge");
        end
    endtask

    task automatic wait_lo_rise();
        int cycles;
        wait_lo_change(1'b0, cycles);
        if (!coil.pwr_lo)
        begin
            wait_lo_change(1'b0, cycles);
        end
    endtask

    task automatic wait_frame_rise();
        logic last;
        int   count;
        bit   seen;
        last  = ssp.frame;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < 600)
        begin
            @(negedge pck0);
            count++;
            seen = ssp.frame && !last;
            last = ssp.frame;
        end
        if (!seen)
        begin
            fail_on_timeout("the start of an SSP frame");
        end
    endtask

    // shifts in ssp.din at each rising ssp.clk, bit 7 first
    task automatic collect_word(output lf_pkg::sample_t word);
        logic clk_last;
        int   bits;
        int   count;
        word     = '0;
        bits     = 0;
        count    = 0;
        clk_last = ssp.clk;
        while (bits < 8 && count < 64)
        begin
            @(negedge pck0);
            count++;
            if (ssp.clk && !clk_last)
            begin
                word = {word[`LF_SAMPLE_W-2:0], ssp.din};
                bits++;
            end
            clk_last = ssp.clk;
        end
        if (bits < 8)
        begin
            fail_on_timeout("eight SSP clock pulses");
        end
    endtask

    // --------------------
    // reference model
    // --------------------

    // a new sample goes out on each falling pwr_lo, and the value present at
    // the rising pwr_lo is the one the reader captured
    always @(negedge pck0)
    begin
        if (reset)
        begin
            lo_prev     = 1'b0;
            model_level = 1'b0;
        end
        else
        begin
            if (coil.pwr_lo && !lo_prev)
            begin
                expected_byte = adc_d;
                if (adc_d >= `LF_EDGE_HI)
                begin
                    model_level = 1'b1;
                end
                else if (adc_d <= `LF_EDGE_LO)
                begin
                    model_level = 1'b0;
                end
            end
            else if (!coil.pwr_lo && lo_prev)
            begin
                adc_d = new_sample(near_thresholds);
            end
            lo_prev = coil.pwr_lo;
        end
    end

    // --------------------
    // test sequence
    // --------------------

    initial
    begin
        lf_pkg::divisor_t divisor;
        lf_pkg::sample_t  word;
        int               cycles;
        int               count;

        pck0            = 1'b0;
        reset           = 1'b1;
        spck            = 1'b0;
        sdata           = 1'b0;
        ncs             = 1'b1;
        adc_d           = '0;
        near_thresholds = 1'b0;
        expected_byte   = '0;
        seed            = 32'h6a79_c0d4;
        checks          = 0;
        errors          = 0;
        tests_run       = 0;

        repeat (3) @(negedge pck0);
        reset = 1'b0;

        // reset leaves the design in off mode
        start_test();
        repeat (300)
        begin
            @(negedge pck0);
            check(outputs_low(), "output active before any configuration");
        end
        finish_test("reset_defaults");

        // half periods follow each new divisor
        start_test();
        repeat (4)
        begin
            divisor = lf_pkg::divisor_t'(`LF_DIV_MIN + ($random(seed) & 16'hffff) % 216);
            write_config(2'b01, divisor, 8);
            // the half period already running still uses the old divisor
            wait_lo_change(1'b0, cycles);
            wait_lo_change(1'b0, cycles);
            repeat (3)
            begin
                wait_lo_change(1'b1, cycles);
                check(cycles == divisor + 1,
                      $sformatf("half period %0d, expected %0d", cycles, divisor + 1));
            end
        end
        finish_test("carrier_period");

        // every carrier cycle sends the captured byte
        start_test();
        repeat (50)
        begin
            wait_frame_rise();
            collect_word(word);
            check(word == expected_byte,
                  $sformatf("SSP word %02h, expected %02h", word, expected_byte));
        end
        finish_test("serial_samples");

        // comparator level replaces the byte
        start_test();
        near_thresholds = 1'b1;
        divisor = lf_pkg::divisor_t'(`LF_DIV_MIN + ($random(seed) & 16'hffff) % 61);
        write_config(2'b10, divisor, 8);
        repeat (60)
        begin
            wait_lo_rise();
            repeat (4)
            begin
                @(negedge pck0);
                check(!ssp.frame && !ssp.clk, "frame or clk active in edge mode");
            end
            check(ssp.din == model_level,
                  $sformatf("level %0b, expected %0b", ssp.din, model_level));
        end
        near_thresholds = 1'b0;
        finish_test("hysteresis");

        // a short divisor is raised, then off mode silences the pins
        start_test();
        write_config(2'b01, 8'd10, 8);
        wait_lo_change(1'b0, cycles);
        wait_lo_change(1'b0, cycles);
        repeat (3)
        begin
            wait_lo_change(1'b1, cycles);
            check(cycles == `LF_DIV_MIN + 1,
                  $sformatf("half period %0d, expected %0d", cycles, `LF_DIV_MIN + 1));
        end
        write_config(2'b00, 8'd95, 0);
        count = 0;
        while (!outputs_low() && count < 10)
        begin
            @(negedge pck0);
            count++;
        end
        check(outputs_low(), "outputs still active 10 cycles after mode_off");
        repeat (100)
        begin
            @(negedge pck0);
            check(outputs_low(), "output active in off mode");
        end
        finish_test("clamp_and_off");

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
rtl/lf_pkg.sv
rtl/lf_config_rx.sv
rtl/lf_reader.sv
rtl/lf_edge_detect.sv
rtl/lf_output_select.sv
rtl/lf_frontend.sv
testbench/lf_frontend_tb.sv
